// ==== mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

    // ==================================================
    // field widths
    // ==================================================
    localparam int wordBits    = 32;
    localparam int regIdxBits  = 5;
    localparam int opcodeBits  = 6;
    localparam int functBits   = 6;
    localparam int shamtBits   = 5;
    localparam int immBits     = 16;
    localparam int targetBits  = 26;

    // ==================================================
    // opcodes and R-type functs
    // ==================================================
    localparam logic [opcodeBits-1:0] opRtype = 6'h00;
    localparam logic [opcodeBits-1:0] opJ     = 6'h02;
    localparam logic [opcodeBits-1:0] opBeq   = 6'h04;
    localparam logic [opcodeBits-1:0] opLw    = 6'h23;
    localparam logic [opcodeBits-1:0] opSw    = 6'h2b;

    localparam logic [functBits-1:0] fnAdd = 6'h20;
    localparam logic [functBits-1:0] fnSub = 6'h22;
    localparam logic [functBits-1:0] fnAnd = 6'h24;
    localparam logic [functBits-1:0] fnOr  = 6'h25;
    localparam logic [functBits-1:0] fnSlt = 6'h2a; // unsigned compare here

    // three views of one instruction word
    typedef struct packed {
        logic [opcodeBits-1:0] opcode;
        logic [regIdxBits-1:0] rs;
        logic [regIdxBits-1:0] rt;
        logic [regIdxBits-1:0] rd;
        logic [shamtBits-1:0]  shamt;  // unused by the kept set
        logic [functBits-1:0]  funct;
    } rFmtWord;

    typedef struct packed {
        logic [opcodeBits-1:0] opcode;
        logic [regIdxBits-1:0] rs;
        logic [regIdxBits-1:0] rt;
        logic [immBits-1:0]    imm;    // offset, sign extended by users
    } iFmtWord;

    typedef struct packed {
        logic [opcodeBits-1:0] opcode;
        logic [targetBits-1:0] target; // word target
    } jFmtWord;

    typedef union packed {
        rFmtWord rFmt;
        iFmtWord iFmt;
        jFmtWord jFmt;
    } instrWord;

endpackage

`default_nettype wire

// ==== mipsAluPkg.sv ====
`default_nettype none

package mipsAluPkg;

    localparam int aluCtrlBits  = 4;
    localparam int aluClassBits = 2;

    // ==================================================
    // ALU operation codes
    // ==================================================
    localparam logic [aluCtrlBits-1:0] aluAnd = 4'b0000;
    localparam logic [aluCtrlBits-1:0] aluOr  = 4'b0001;
    localparam logic [aluCtrlBits-1:0] aluAdd = 4'b0010;
    localparam logic [aluCtrlBits-1:0] aluSub = 4'b0110;
    localparam logic [aluCtrlBits-1:0] aluSlt = 4'b0111;

    // operation class handed from main decode to ALU decode
    localparam logic [aluClassBits-1:0] aluClassMem    = 2'b00; // address add
    localparam logic [aluClassBits-1:0] aluClassBranch = 2'b01; // compare by sub
    localparam logic [aluClassBits-1:0] aluClassFunct  = 2'b10; // look at funct

endpackage

`default_nettype wire

// ==== aluUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluUnit
    import mipsIsaPkg::*;
    import mipsAluPkg::*;
(
    input  logic [aluCtrlBits-1:0] aluCtrl,
    input  logic [wordBits-1:0]    opA,
    input  logic [wordBits-1:0]    opB,
    output logic [wordBits-1:0]    result,
    output logic                   zero
);

    always_comb begin
        case (aluCtrl)
            aluAdd: result = opA + opB;
            aluSub: result = opA - opB; // wraps around
            aluAnd: result = opA & opB;
            aluOr:  result = opA | opB;
            aluSlt: begin
                result = '0;
                result[0] = (opA < opB); // unsigned
            end
            default: result = '0;
        endcase
    end

    // beq looks at this after a sub
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile
    import mipsIsaPkg::*;
(
    input  logic                  Clk,
    input  logic                  reset,      // active low
    input  logic                  writeEn,
    input  logic [regIdxBits-1:0] writeIdx,
    input  logic [regIdxBits-1:0] readIdxA,
    input  logic [regIdxBits-1:0] readIdxB,
    input  logic [wordBits-1:0]   writeData,
    output logic [wordBits-1:0]   readDataA,
    output logic [wordBits-1:0]   readDataB
);

    localparam int numRegs = 2 ** regIdxBits;

    // register 0 is not stored
    logic [wordBits-1:0] regs [1:numRegs-1];

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData; // writes to r0 vanish
        end
    end

    // ==================================================
    // read ports, combinational
    // ==================================================
    always_comb begin
        readDataA = '0;
        readDataB = '0;
        if (readIdxA != '0) begin
            readDataA = regs[readIdxA];
        end
        if (readIdxB != '0) begin
            readDataB = regs[readIdxB];
        end
    end

endmodule

`default_nettype wire

// ==== pcUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcUnit
    import mipsIsaPkg::*;
#(
    parameter logic [wordBits-1:0] resetPc = '0
) (
    input  logic                Clk,
    input  logic                reset,     // active low
    input  var instrWord        instr,
    input  logic                branch,
    input  logic                jump,
    input  logic                aluZero,
    output logic [wordBits-1:0] pc
);

    logic [wordBits-1:0] pcPlus4;
    logic [wordBits-1:0] branchTarget;
    logic [wordBits-1:0] jumpTarget;
    logic [wordBits-1:0] nextPc;

    assign pcPlus4 = pc + wordBits'(4);

    // word offset, sign extended then shifted left two
    assign branchTarget = pcPlus4
        + {{(wordBits-immBits-2){instr.iFmt.imm[immBits-1]}}, instr.iFmt.imm, 2'b00};

    // top four of pc+4 with the target
    assign jumpTarget = {pcPlus4[wordBits-1 -: 4], instr.jFmt.target, 2'b00};

    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branch && aluZero) begin
            nextPc = branchTarget; // taken beq
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
    import mipsIsaPkg::*;
    import mipsAluPkg::*;
(
    input  var instrWord               instr,
    output logic                       regWrite,
    output logic                       regDstRd,   // rd when high, rt otherwise
    output logic                       aluSrcImm,  // immediate as operand b
    output logic                       memToReg,
    output logic                       memWrite,
    output logic                       branch,
    output logic                       jump,
    output logic [aluCtrlBits-1:0]     aluCtrl
);

    logic                    mainRegWrite; // before the funct check
    logic [aluClassBits-1:0] aluClass;
    logic                    fnKnown;

    // ==================================================
    // main decode on the opcode
    // ==================================================
    always_comb begin
        mainRegWrite = 1'b0;
        regDstRd     = 1'b0;
        aluSrcImm    = 1'b0;
        memToReg     = 1'b0;
        memWrite     = 1'b0;
        branch       = 1'b0;
        jump         = 1'b0;
        aluClass     = aluClassMem;
        case (instr.rFmt.opcode)
            opRtype: begin
                mainRegWrite = 1'b1;
                regDstRd     = 1'b1;
                aluClass     = aluClassFunct;
            end
            opLw: begin
                mainRegWrite = 1'b1;
                aluSrcImm    = 1'b1;
                memToReg     = 1'b1; // write back from memory
            end
            opSw: begin
                aluSrcImm    = 1'b1;
                memWrite     = 1'b1;
            end
            opBeq: begin
                branch       = 1'b1;
                aluClass     = aluClassBranch; // zero flag on equal
            end
            opJ: begin
                jump         = 1'b1;
            end
            default: ; // unknown opcode, all enables stay low
        endcase
    end

    // ==================================================
    // ALU control decode
    // ==================================================
    always_comb begin
        fnKnown = 1'b1;
        aluCtrl = aluAdd;
        case (aluClass)
            aluClassMem:    aluCtrl = aluAdd;
            aluClassBranch: aluCtrl = aluSub;
            aluClassFunct: begin
                case (instr.rFmt.funct)
                    fnAdd:   aluCtrl = aluAdd;
                    fnSub:   aluCtrl = aluSub;
                    fnAnd:   aluCtrl = aluAnd;
                    fnOr:    aluCtrl = aluOr;
                    fnSlt:   aluCtrl = aluSlt;
                    default: fnKnown = 1'b0; // unknown funct
                endcase
            end
            default: aluCtrl = aluAdd;
        endcase
    end

    // unknown funct turns the R-type into a no-op
    assign regWrite = mainRegWrite & fnKnown;

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCore
    import mipsIsaPkg::*;
    import mipsAluPkg::*;
#(
    parameter logic [wordBits-1:0] resetPc      = '0,
    parameter int                  dataAddrBits = 7
) (
    input  logic                    Clk,
    input  logic                    reset,       // active low
    // instruction memory
    input  var instrWord            instr,
    output logic [wordBits-1:0]     instrAddr,
    // data memory
    input  logic [wordBits-1:0]     dataRdata,
    output logic [dataAddrBits-1:0] dataAddr,    // word address
    output logic [wordBits-1:0]     dataWdata,
    output logic                    dataWe,
    // write-back observation
    output logic [wordBits-1:0]     rfWriteData
);

    // control
    logic                   regWrite;
    logic                   regDstRd;
    logic                   aluSrcImm;
    logic                   memToReg;
    logic                   memWrite;
    logic                   branch;
    logic                   jump;
    logic [aluCtrlBits-1:0] aluCtrl;

    // datapath
    logic [wordBits-1:0]    readDataA;
    logic [wordBits-1:0]    readDataB;
    logic [wordBits-1:0]    signExtImm;
    logic [wordBits-1:0]    aluOpB;
    logic [wordBits-1:0]    aluResult;
    logic                   aluZero;
    logic [regIdxBits-1:0]  writeIdx;

    // ==================================================
    // fetch and decode
    // ==================================================
    pcUnit #(
        .resetPc (resetPc)
    ) pcUnit_i (
        .Clk     (Clk),
        .reset   (reset),
        .instr   (instr),
        .branch  (branch),
        .jump    (jump),
        .aluZero (aluZero),
        .pc      (instrAddr)
    );

    instrDecoder instrDecoder_i (
        .instr     (instr),
        .regWrite  (regWrite),
        .regDstRd  (regDstRd),
        .aluSrcImm (aluSrcImm),
        .memToReg  (memToReg),
        .memWrite  (memWrite),
        .branch    (branch),
        .jump      (jump),
        .aluCtrl   (aluCtrl)
    );

    // ==================================================
    // register read, execute, write back
    // ==================================================
    assign writeIdx = regDstRd ? instr.rFmt.rd : instr.rFmt.rt; // rd for R-type

    regFile regFile_i (
        .Clk       (Clk),
        .reset     (reset),
        .writeEn   (regWrite),
        .writeIdx  (writeIdx),
        .readIdxA  (instr.rFmt.rs),
        .readIdxB  (instr.rFmt.rt),
        .writeData (rfWriteData),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    assign signExtImm = {{(wordBits-immBits){instr.iFmt.imm[immBits-1]}}, instr.iFmt.imm};
    assign aluOpB     = aluSrcImm ? signExtImm : readDataB;

    aluUnit aluUnit_i (
        .aluCtrl (aluCtrl),
        .opA     (readDataA),
        .opB     (aluOpB),
        .result  (aluResult),
        .zero    (aluZero)
    );

    // memory port, byte address bits dropped
    assign dataAddr    = aluResult[dataAddrBits+1:2];
    assign dataWdata   = readDataB;
    assign dataWe      = memWrite; // sw only
    assign rfWriteData = memToReg ? dataRdata : aluResult;

endmodule

`default_nettype wire

// ==== tbMipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbMipsCore
    import mipsIsaPkg::*;
();

    localparam logic [31:0] resetPc      = 32'h0;
    localparam int          dataAddrBits = 7;
    localparam int          numSteps     = 300;   // instruction budget

    logic        Clk;
    logic        reset;
    instrWord    instr;
    logic [31:0] dataRdata;
    logic [31:0] instrAddr;
    logic [6:0]  dataAddr;
    logic [31:0] dataWdata;
    logic        dataWe;
    logic [31:0] rfWriteData;

    logic [31:0] rom [0:63];
    logic [31:0] ram [0:127];      // memory seen by the DUT
    logic [31:0] refRam [0:127];   // model copy
    logic [31:0] refRegs [0:31];
    logic [31:0] refPc;
    logic [31:0] lfsrState;
    logic        running;
    int          mismatches;
    int          timeouts;
    int          stepsDone;
    int          cycles;

    // expected values for the current instruction
    logic        expWe;
    logic        expRegWrite;
    logic [6:0]  expAddr;
    logic [31:0] expWdata;
    logic [31:0] expWb;

    mipsCore #(
        .resetPc      (resetPc),
        .dataAddrBits (dataAddrBits)
    ) mipsCore_i (
        .Clk         (Clk),
        .reset       (reset),
        .instr       (instr),
        .instrAddr   (instrAddr),
        .dataRdata   (dataRdata),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .dataWe      (dataWe),
        .rfWriteData (rfWriteData)
    );

    always #50 Clk = ~Clk;   // 100 ns period

    // ==================================================
    // program generation
    // ==================================================
    // galois lfsr stepped once per bit
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs, rt, rd);
        return {opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic loadProgram();
        logic [2:0]  kind;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] off;
        int          tgt;
        rom[0]  = iWord(opLw, 5'd0, 5'd1, 16'd4);
        rom[1]  = iWord(opLw, 5'd0, 5'd2, 16'd8);
        rom[2]  = rWord(fnSub, 5'd1, 5'd2, 5'd3);   // wraps below zero
        rom[3]  = rWord(fnSlt, 5'd1, 5'd2, 5'd4);   // 1 unsigned where signed gives 0
        rom[4]  = rWord(fnAdd, 5'd1, 5'd2, 5'd0);   // r0 target
        rom[5]  = rWord(fnAdd, 5'd0, 5'd2, 5'd5);
        rom[6]  = iWord(opSw, 5'd0, 5'd3, 16'd12);
        rom[7]  = iWord(opLw, 5'd0, 5'd6, 16'd12);  // reads back the store
        rom[8]  = 32'hfc00_0000;                     // unknown opcode
        rom[9]  = rWord(6'h3f, 5'd1, 5'd2, 5'd7);   // unknown funct
        rom[10] = iWord(opBeq, 5'd1, 5'd1, 16'd1);  // taken
        rom[11] = rWord(fnOr, 5'd1, 5'd2, 5'd7);
        rom[12] = iWord(opBeq, 5'd1, 5'd2, 16'd5);  // not taken
        rom[13] = {opJ, 26'd15};
        rom[14] = rWord(fnAnd, 5'd1, 5'd2, 5'd7);
        for (int i = 15; i < 64; i++) begin
            kind = 3'(lfsrBits(3));
            rs   = 5'(lfsrBits(3));
            rt   = 5'(lfsrBits(3));
            rd   = 5'(lfsrBits(3));
            case (kind)
                3'd4:    rom[i] = iWord(opLw, 5'd0, rt, 16'(lfsrBits(4)) << 2);
                3'd5:    rom[i] = iWord(opSw, 5'd0, rt, 16'(lfsrBits(4)) << 2);
                3'd6: begin
                    tgt    = (i + 1 + int'(lfsrBits(3))) % 64;
                    off    = 16'(tgt - i - 1);   // negative when the target wraps
                    rom[i] = iWord(opBeq, rs, rt, off);
                end
                3'd7: begin
                    tgt    = (i + 2 + int'(lfsrBits(2))) % 64;
                    rom[i] = {opJ, 26'(tgt)};
                end
                default: begin
                    case (3'(lfsrBits(3)))
                        3'd0:    fn = fnAdd;
                        3'd1:    fn = fnSub;
                        3'd2:    fn = fnAnd;
                        3'd3:    fn = fnOr;
                        default: fn = fnSlt;
                    endcase
                    rom[i] = rWord(fn, rs, rt, rd);
                end
            endcase
        end
    endtask

    // ==================================================
    // reference model stepping one instruction per call
    // ==================================================
    function automatic void refStep(input instrWord w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] pcPlus4;
        logic [31:0] pcNext;
        logic [4:0]  dest;
        a           = refRegs[w.rFmt.rs];
        b           = refRegs[w.rFmt.rt];
        imm         = {{16{w.iFmt.imm[15]}}, w.iFmt.imm};
        addr        = a + imm;
        pcPlus4     = refPc + 32'd4;
        pcNext      = pcPlus4;
        dest        = w.rFmt.rt;
        expWe       = 1'b0;
        expRegWrite = 1'b0;
        expAddr     = addr[8:2];
        expWdata    = b;
        expWb       = '0;
        case (w.rFmt.opcode)
            opRtype: begin
                dest        = w.rFmt.rd;
                expRegWrite = 1'b1;
                case (w.rFmt.funct)
                    fnAdd:   expWb = a + b;
                    fnSub:   expWb = a - b;
                    fnAnd:   expWb = a & b;
                    fnOr:    expWb = a | b;
                    fnSlt:   expWb = (a < b) ? 32'd1 : 32'd0;
                    default: expRegWrite = 1'b0;   // acts as no-op
                endcase
            end
            opLw: begin
                expWb       = refRam[addr[8:2]];
                expRegWrite = 1'b1;
            end
            opSw: begin
                expWe              = 1'b1;
                refRam[addr[8:2]]  = b;
            end
            opBeq:   if (a == b) pcNext = pcPlus4 + {imm[29:0], 2'b00};
            opJ:     pcNext = {pcPlus4[31:28], w.jFmt.target, 2'b00};
            default: ;
        endcase
        if (expRegWrite && dest != 5'd0) begin
            refRegs[dest] = expWb;   // r0 stays zero
        end
        refPc = pcNext;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got, exp);
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        mismatches++;
    endtask

    // ==================================================
    // memories, driver and compare
    // ==================================================
    always @(negedge Clk) begin
        if (running) begin
            instr <= rom[instrAddr[7:2]];
            #5;
            dataRdata <= ram[dataAddr];   // after address settles
        end
    end

    always @(posedge Clk) begin
        if (dataWe) begin
            ram[dataAddr] <= dataWdata;
        end
    end

    always @(negedge Clk) begin
        if (running) begin
            #20;   // outputs settled
            if (instrAddr !== refPc) reportMismatch("instrAddr", instrAddr, refPc);
            refStep(rom[refPc[7:2]]);
            if (dataWe !== expWe) reportMismatch("dataWe", 32'(dataWe), 32'(expWe));
            if (expWe && dataAddr !== expAddr) begin
                reportMismatch("dataAddr", 32'(dataAddr), 32'(expAddr));
            end
            if (expWe && dataWdata !== expWdata) reportMismatch("dataWdata", dataWdata, expWdata);
            if (expRegWrite && rfWriteData !== expWb) begin
                reportMismatch("rfWriteData", rfWriteData, expWb);
            end
            stepsDone++;
        end
    end

    initial begin
        Clk        = 1'b0;
        reset      = 1'b0;
        instr      = '0;   // r-type no-op into r0
        dataRdata  = '0;
        running    = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        stepsDone  = 0;
        lfsrState  = 32'h94e8;
        refPc      = resetPc;
        for (int a = 0; a < 128; a++) begin
            ram[a]    = 32'(a + 1) * 32'h9e37_79b9;
            refRam[a] = ram[a];
        end
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        loadProgram();
        @(negedge Clk);
        #20;
        if (instrAddr !== resetPc) reportMismatch("instrAddr", instrAddr, resetPc);
        if (dataWe !== 1'b0) reportMismatch("dataWe", 32'(dataWe), 32'd0);
        @(posedge Clk);
        running = 1'b1;
        @(negedge Clk);
        reset <= 1'b1;   // after two rising edges
        cycles = 0;
        while (stepsDone < numSteps && cycles < numSteps + 20) begin
            @(posedge Clk);
            cycles++;
        end
        if (stepsDone < numSteps) begin
            $display("timeout: only %0d of %0d instructions were checked", stepsDone, numSteps);
            timeouts++;
        end
        $display("instructions %0d, mismatches %0d, timeouts %0d",
                 stepsDone, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
mipsIsaPkg.sv
mipsAluPkg.sv
aluUnit.sv
regFile.sv
pcUnit.sv
instrDecoder.sv
mipsCore.sv
tbMipsCore.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tbMipsCore -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
